// File: cpu_cases.txt
// per case: name (ascii), program word count, program words, write count, writes
// a write is address << 8 | byte, in bus order; a zero name ends the file
616C7520 0000002A
FF900093 00300113
00508193 40302023 FFF0A193 40302223 0050B193 40302423 0F00C193 40302623
0A416193 40302823 03C0F193 40302A23 00409193 40302C23 0040D193 40302E23
4020D193 42302023 002081B3 42302223 402081B3 42302423 002091B3 42302623
0020A1B3 42302823 0020B1B3 42302A23 0020C1B3 42302C23 0020D1B3 42302E23
4020D1B3 44302023 0020E1B3 44302223 0020F1B3 44302423 00030FB7 000F8223
0000004D
000400FE 000401FF 000402FF 000403FF 00040401 00040500 00040600 00040700
00040800 00040900 00040A00 00040B00 00040C09 00040DFF 00040EFF 00040FFF
000410A7 00041100 00041200 00041300 00041438 00041500 00041600 00041700
00041890 000419FF 00041AFF 00041BFF 00041CFF 00041DFF 00041EFF 00041F0F
000420FE 000421FF 000422FF 000423FF 000424FC 000425FF 000426FF 000427FF
000428F6 000429FF 00042AFF 00042BFF 00042CC8 00042DFF 00042EFF 00042FFF
00043001 00043100 00043200 00043300 00043400 00043500 00043600 00043700
000438FA 000439FF 00043AFF 00043BFF 00043CFF 00043DFF 00043EFF 00043F1F
000440FF 000441FF 000442FF 000443FF 000444FB 000445FF 000446FF 000447FF
00044801 00044900 00044A00 00044B00 03000400
6C6F6164 0000000F
91C382B7 A8528293 50502023 50000303 50602823 50201303 50602A23 50002303
50602C23 50004303 50602E23 50205303 52602023 00030FB7 000F8223
00000019
00050085 0005017A 000502C3 00050391 00051085 000511FF 000512FF 000513FF
000514C3 00051591 000516FF 000517FF 00051885 0005197A 00051AC3 00051B91
00051C85 00051D00 00051E00 00051F00 000520C3 00052191 00052200 00052300
03000400
6374726C 00000023
FF900093 00300113 05A00393
00108463 6E700FA3 00208463 60700023 00209463 6E700FA3 00109463 607000A3
0020C463 6E700FA3 00114463 60700123 00115463 6E700FA3 0020D463 607001A3
00116463 6E700FA3 0020E463 60700223 0020F463 6E700FA3 00117463 607002A3
0080046F 6E700FA3 60802823 011404E7 6E700FA3 60902A23 00030FB7 000F8223
0000000F
0006005A 0006015A 0006025A 0006035A 0006045A 0006055A
00061070 00061100 00061200 00061300 0006147C 00061500 00061600 00061700
03000400
6C616E65 0000000A
A1B2C2B7 3D428293 70500023 705000A3 70500123 705001A3 70501423 70501523
00030FB7 000F8223
00000009
000700D4 000701D4 000702D4 000703D4 000708D4 000709C3 00070AD4 00070BC3
03000400
00000000

// File: flist.f
cpu_pkg.sv
mem_req_if.sv
alu.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_port.sv
cpu_top.sv
tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_cpu -f flist.f -o sim_tb_cpu &&
./obj_dir/sim_tb_cpu | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_cpu.sv
// testbench for the rv32i core
// runs each program from the case file on a byte memory and checks every bus write
`timescale 1ns/100ps

module tb_cpu;
	import cpu_pkg::*;

	localparam int CASE_WORDS = 512;
	localparam int MEM_BYTES = 131072;
	localparam mem_addr_t HALT_ADDR = 18'h30004;
	localparam mem_addr_t RESET_ADDR = 18'h00000;

	logic clk_in;
	logic rst_in;
	logic rdy_in = 1'b1;
	byte_t mem_din = '0;
	byte_t mem_dout;
	logic [31:0] mem_a;
	logic mem_wr;

	word_t cases [CASE_WORDS];
	byte_t mem [MEM_BYTES];
	logic [16:0] addr_prev = '0;
	logic active;
	logic halted;
	logic pausing;
	int exp_base;
	int exp_cnt;
	int exp_pos;
	int limit_cycles;
	int stall_left;
	logic [31:0] rnd;

	cpu_top #(
		.RESET_PC('0)
	) uut (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.rdy_in(rdy_in),
		.mem_din(mem_din),
		.mem_dout(mem_dout),
		.mem_a(mem_a),
		.mem_wr(mem_wr)
	);

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	// read byte follows the address of the previous cycle
	always @(negedge clk_in) begin
		mem_din = mem[addr_prev];
		addr_prev = mem_a[16:0];
		if (!pausing) begin
			rdy_in = 1'b1;
		end else if (stall_left > 0) begin
			rdy_in = 1'b0;
			stall_left--;
		end else begin
			rnd = xorshift(rnd);
			rdy_in = (rnd[3:0] != 4'd0);
			stall_left = rdy_in ? 0 : int'(rnd[7:4]);
		end
	end

	task automatic take_write(input mem_addr_t a, input byte_t d);
		word_t e;
		if (exp_pos >= exp_cnt) begin
			stop_with_error($sformatf("unexpected bus write to address %h", a));
		end else begin
			e = cases[exp_base + exp_pos];
			check_addr("mem_a", a, e[8 +: MEM_ADDR_W]);
			check_byte("mem_dout", d, e[7:0]);
			exp_pos++;
			if (a == HALT_ADDR) begin
				halted = 1'b1;
			end else if (a < mem_addr_t'(MEM_BYTES)) begin
				mem[a[16:0]] = d;
			end
		end
	endtask

	always @(posedge clk_in) begin
		if (mem_a[31:MEM_ADDR_W] !== '0) begin
			stop_with_error("mem_a drives address bits above the bus address width");
		end
		if (rst_in && mem_wr) begin
			stop_with_error("bus write while reset is asserted");
		end else if (active && !halted && mem_wr) begin
			if (!rdy_in) begin
				stop_with_error("bus write while rdy_in is low");
			end else begin
				take_write(mem_a[MEM_ADDR_W-1:0], mem_dout);
			end
		end
	end

	task automatic run_case(input int pos);
		word_t name;
		word_t w;
		int nprog;
		name = cases[pos];
		nprog = int'(cases[pos + 1]);
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = byte_t'(i ^ (i >> 8) ^ (i >> 16));
		end
		for (int i = 0; i < nprog; i++) begin
			w = cases[pos + 2 + i];
			for (int b = 0; b < 4; b++) begin
				mem[4 * i + b] = w[8 * b +: 8];
			end
		end
		exp_cnt = int'(cases[pos + 2 + nprog]);
		exp_base = pos + 3 + nprog;
		exp_pos = 0;
		halted = 1'b0;
		$display("case %s, paused %0d", name, pausing);
		@(negedge clk_in);
		rst_in = 1'b1;
		repeat (4) @(negedge clk_in);
		rst_in = 1'b0;
		active = 1'b1;
		@(negedge clk_in);
		if (mem_wr) begin
			stop_with_error("bus write in the first cycle after reset");
		end
		@(negedge clk_in);
		check_addr("mem_a", mem_a[MEM_ADDR_W-1:0], RESET_ADDR);
		wait (halted);
		@(negedge clk_in);
		active = 1'b0;
		if (exp_pos != exp_cnt) begin
			stop_with_error($sformatf("case %s ended after %0d of %0d writes",
				name, exp_pos, exp_cnt));
		end
	endtask

	initial begin
		int pos;
		int total;
		int nprog;
		int nwr;
		rst_in = 1'b1;
		active = 1'b0;
		halted = 1'b0;
		pausing = 1'b0;
		stall_left = 0;
		rnd = 32'd37;
		limit_cycles = 0;
		exp_base = 0;
		exp_cnt = 0;
		exp_pos = 0;
		$readmemh("cpu_cases.txt", cases);
		total = 0;
		pos = 0;
		while (cases[pos] != '0) begin
			nprog = int'(cases[pos + 1]);
			nwr = int'(cases[pos + 2 + nprog]);
			total += nprog;
			pos += 3 + nprog + nwr;
		end
		// both passes run every case
		limit_cycles = 2 * total * 40 * 20 + 100;
		for (int pass = 0; pass < 2; pass++) begin
			pausing = (pass == 1);
			pos = 0;
			while (cases[pos] != '0) begin
				run_case(pos);
				nprog = int'(cases[pos + 1]);
				pos += 3 + nprog + int'(cases[pos + 2 + nprog]);
			end
		end
		if (total == 0) begin
			stop_with_error("no cases were found in the case file");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk_in);
		stop_with_error("program never halted before the watchdog ran out");
	end

endmodule

// File: cpu_top.sv
// rv32i core top level
// fetch, decode and execute sharing one byte-wide memory bus
`timescale 1ns/100ps

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input cpu_pkg::byte_t mem_din,
	output cpu_pkg::byte_t mem_dout,
	output logic [31:0] mem_a,
	output logic mem_wr
);
	import cpu_pkg::*;

	mem_req_if fetch_mem ();
	mem_req_if lsu_mem ();

	logic dec_start;
	logic ex_start;
	logic retire;
	logic wr_en;
	word_t instr, pc, next_pc;
	word_t ex_instr, ex_pc, op_a, op_b, imm;
	word_t rs1_data, rs2_data, wr_data;
	reg_idx_t rs1_idx, rs2_idx, wr_idx;
	alu_op_e alu_op;
	mem_addr_t bus_addr;

	assign mem_a = {{(32 - MEM_ADDR_W){1'b0}}, bus_addr};

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.rdy_in(rdy_in),
		.retire(retire),
		.next_pc(next_pc),
		.mem(fetch_mem.client),
		.dec_start(dec_start),
		.instr(instr),
		.pc(pc)
	);

	decode_stage u_decode (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.rdy_in(rdy_in),
		.dec_start(dec_start),
		.instr(instr),
		.pc(pc),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex_start(ex_start),
		.ex_instr(ex_instr),
		.ex_pc(ex_pc),
		.op_a(op_a),
		.op_b(op_b),
		.imm(imm),
		.alu_op(alu_op)
	);

	reg_file u_regs (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	execute_stage u_execute (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.rdy_in(rdy_in),
		.ex_start(ex_start),
		.ex_instr(ex_instr),
		.ex_pc(ex_pc),
		.op_a(op_a),
		.op_b(op_b),
		.imm(imm),
		.alu_op(alu_op),
		.mem(lsu_mem.client),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.retire(retire),
		.next_pc(next_pc)
	);

	mem_port u_mem_port (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.rdy_in(rdy_in),
		.mem_din(mem_din),
		.fetch_mem(fetch_mem.port),
		.lsu_mem(lsu_mem.port),
		.mem_dout(mem_dout),
		.mem_a(bus_addr),
		.mem_wr(mem_wr)
	);

endmodule

// File: mem_port.sv
// memory port
// serves fetch and load/store requests as byte cycles on the shared bus
`timescale 1ns/100ps

module mem_port (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input cpu_pkg::byte_t mem_din,
	mem_req_if.port fetch_mem,
	mem_req_if.port lsu_mem,
	output cpu_pkg::byte_t mem_dout,
	output cpu_pkg::mem_addr_t mem_a,
	output logic mem_wr
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_addr,
		st_data,
		st_done,
		st_release
	} port_state_e;

	port_state_e state;
	logic sel_lsu;
	logic we_q;
	logic wr_q;
	logic ack_q;
	logic [1:0] cnt;
	logic [1:0] cnt_nxt;
	logic last;
	logic cur_req;
	mem_size_e size_q;
	mem_addr_t base_q;
	word_t wdata_q;
	word_t rdata_q;

	// incoming request, load/store wins
	logic in_we;
	mem_size_e in_size;
	mem_addr_t in_addr;
	word_t in_wdata;

	assign in_we = lsu_mem.req ? lsu_mem.we : fetch_mem.we;
	assign in_size = lsu_mem.req ? lsu_mem.size : fetch_mem.size;
	assign in_addr = lsu_mem.req ? lsu_mem.addr : fetch_mem.addr;
	assign in_wdata = lsu_mem.req ? lsu_mem.wdata : fetch_mem.wdata;

	assign cur_req = sel_lsu ? lsu_mem.req : fetch_mem.req;
	assign cnt_nxt = cnt + 2'd1;
	assign last = (cnt == size_q);

	assign fetch_mem.ack = ack_q && !sel_lsu;
	assign lsu_mem.ack = ack_q && sel_lsu;
	assign fetch_mem.rdata = rdata_q;
	assign lsu_mem.rdata = rdata_q;

	// a paused write byte is held back and repeated once ready
	assign mem_wr = wr_q && rdy_in;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= st_idle;
			sel_lsu <= 1'b0;
			wr_q <= 1'b0;
			ack_q <= 1'b0;
			cnt <= 2'd0;
			mem_a <= '0;
		end else if (rdy_in) begin
			case (state)
				st_idle: begin
					if (lsu_mem.req || fetch_mem.req) begin
						sel_lsu <= lsu_mem.req;
						we_q <= in_we;
						size_q <= in_size;
						base_q <= in_addr;
						wdata_q <= in_wdata;
						rdata_q <= '0;
						cnt <= 2'd0;
						mem_a <= in_addr;
						mem_dout <= in_wdata[7:0];
						wr_q <= in_we;
						state <= st_addr;
					end
				end
				st_addr: begin
					if (!we_q) begin
						state <= st_data;
					end else if (last) begin
						wr_q <= 1'b0;
						ack_q <= 1'b1;
						state <= st_done;
					end else begin
						cnt <= cnt_nxt;
						mem_a <= base_q + mem_addr_t'(cnt_nxt);
						mem_dout <= wdata_q[{cnt_nxt, 3'b000} +: 8];
					end
				end
				st_data: begin
					// byte for the address driven one cycle earlier
					rdata_q[{cnt, 3'b000} +: 8] <= mem_din;
					if (last) begin
						ack_q <= 1'b1;
						state <= st_done;
					end else begin
						cnt <= cnt_nxt;
						mem_a <= base_q + mem_addr_t'(cnt_nxt);
						state <= st_addr;
					end
				end
				st_done: begin
					if (!cur_req) begin
						ack_q <= 1'b0;
						state <= st_release;
					end
				end
				st_release: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// File: execute_stage.sv
// execute stage
// branches, jumps, loads and stores, then write back and retire
`timescale 1ns/100ps

module execute_stage (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input logic ex_start,
	input cpu_pkg::word_t ex_instr,
	input cpu_pkg::word_t ex_pc,
	input cpu_pkg::word_t op_a,
	input cpu_pkg::word_t op_b,
	input cpu_pkg::word_t imm,
	input cpu_pkg::alu_op_e alu_op,
	mem_req_if.client mem,
	output logic wr_en,
	output cpu_pkg::reg_idx_t wr_idx,
	output cpu_pkg::word_t wr_data,
	output logic retire,
	output cpu_pkg::word_t next_pc
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_mem,
		st_drop
	} ex_state_e;

	ex_state_e state;
	opcode_e opcode;
	logic [2:0] funct3;
	logic req_q;
	logic taken;
	logic writes_rd;
	word_t alu_y;
	word_t link;
	word_t ea;
	word_t target;
	word_t load_val;

	assign opcode = opcode_e'(ex_instr[6:0]);
	assign funct3 = ex_instr[14:12];
	assign link = ex_pc + 32'd4;
	assign ea = op_a + imm;
	assign writes_rd = opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg};

	alu u_alu (
		.op(alu_op),
		.a(op_a),
		.b(op_b),
		.y(alu_y)
	);

	always_comb begin
		case (funct3)
			3'b000: taken = (op_a == op_b);
			3'b001: taken = (op_a != op_b);
			3'b100: taken = ($signed(op_a) < $signed(op_b));
			3'b101: taken = ($signed(op_a) >= $signed(op_b));
			3'b110: taken = (op_a < op_b);
			3'b111: taken = (op_a >= op_b);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			op_jal: target = ex_pc + imm;
			op_jalr: target = {ea[31:1], 1'b0};
			op_branch: target = taken ? ex_pc + imm : link;
			default: target = link;
		endcase
	end

	// rdata arrives zero-filled, so only lb and lh need work
	always_comb begin
		case (funct3)
			3'b000: load_val = {{24{mem.rdata[7]}}, mem.rdata[7:0]};
			3'b001: load_val = {{16{mem.rdata[15]}}, mem.rdata[15:0]};
			default: load_val = mem.rdata;
		endcase
	end

	assign mem.req = req_q;
	assign mem.we = (opcode == op_store);
	assign mem.addr = ea[MEM_ADDR_W-1:0];
	assign mem.wdata = op_b;

	always_comb begin
		case (funct3[1:0])
			2'b00: mem.size = size_byte;
			2'b01: mem.size = size_half;
			default: mem.size = size_word;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= st_idle;
			req_q <= 1'b0;
			retire <= 1'b0;
			wr_en <= 1'b0;
		end else if (rdy_in) begin
			retire <= 1'b0;
			wr_en <= 1'b0;
			case (state)
				st_idle: begin
					if (ex_start && (opcode == op_load || opcode == op_store)) begin
						req_q <= 1'b1;
						state <= st_mem;
					end else if (ex_start) begin
						retire <= 1'b1;
						next_pc <= target;
						wr_en <= writes_rd;
						wr_idx <= ex_instr[11:7];
						wr_data <= (opcode == op_jal || opcode == op_jalr) ? link : alu_y;
					end
				end
				st_mem: begin
					if (mem.ack) begin
						req_q <= 1'b0;
						retire <= 1'b1;
						next_pc <= link;
						wr_en <= (opcode == op_load);
						wr_idx <= ex_instr[11:7];
						wr_data <= load_val;
						state <= st_drop;
					end
				end
				st_drop: begin
					if (!mem.ack) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// File: decode_stage.sv
// decode stage
// reads operands, builds the immediate and picks the alu operation
`timescale 1ns/100ps

module decode_stage (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input logic dec_start,
	input cpu_pkg::word_t instr,
	input cpu_pkg::word_t pc,
	output cpu_pkg::reg_idx_t rs1_idx,
	output cpu_pkg::reg_idx_t rs2_idx,
	input cpu_pkg::word_t rs1_data,
	input cpu_pkg::word_t rs2_data,
	output logic ex_start,
	output cpu_pkg::word_t ex_instr,
	output cpu_pkg::word_t ex_pc,
	output cpu_pkg::word_t op_a,
	output cpu_pkg::word_t op_b,
	output cpu_pkg::word_t imm,
	output cpu_pkg::alu_op_e alu_op
);
	import cpu_pkg::*;

	opcode_e opcode;
	word_t imm_c;
	alu_op_e alu_op_c;
	logic use_imm;

	assign opcode = opcode_e'(instr[6:0]);
	assign rs1_idx = instr[19:15];
	assign rs2_idx = instr[24:20];
	assign use_imm = (opcode == op_imm) || (opcode == op_lui) || (opcode == op_auipc);

	always_comb begin
		case (opcode)
			op_store: imm_c = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			op_branch: imm_c = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			op_lui, op_auipc: imm_c = {instr[31:12], 12'b0};
			op_jal: imm_c = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: imm_c = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	// bit 30 only selects sub on register forms, srai carries it in the immediate
	always_comb begin
		alu_op_c = alu_add;
		if (opcode == op_reg || opcode == op_imm) begin
			case (instr[14:12])
				3'b000: alu_op_c = (opcode == op_reg && instr[30]) ? alu_sub : alu_add;
				3'b001: alu_op_c = alu_sll;
				3'b010: alu_op_c = alu_slt;
				3'b011: alu_op_c = alu_sltu;
				3'b100: alu_op_c = alu_xor;
				3'b101: alu_op_c = instr[30] ? alu_sra : alu_srl;
				3'b110: alu_op_c = alu_or;
				default: alu_op_c = alu_and;
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			ex_start <= 1'b0;
		end else if (rdy_in) begin
			ex_start <= dec_start;
			if (dec_start) begin
				ex_instr <= instr;
				ex_pc <= pc;
				imm <= imm_c;
				alu_op <= alu_op_c;
				// lui and auipc go through the adder as 0 + imm and pc + imm
				case (opcode)
					op_lui: op_a <= '0;
					op_auipc: op_a <= pc;
					default: op_a <= rs1_data;
				endcase
				op_b <= use_imm ? imm_c : rs2_data;
			end
		end
	end

endmodule

// File: fetch_stage.sv
// fetch stage
// holds the pc and reads one instruction word per retired instruction
`timescale 1ns/100ps

module fetch_stage #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input logic retire,
	input cpu_pkg::word_t next_pc,
	mem_req_if.client mem,
	output logic dec_start,
	output cpu_pkg::word_t instr,
	output cpu_pkg::word_t pc
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_wait_ack,
		st_wait_drop,
		st_wait_retire
	} fetch_state_e;

	fetch_state_e state;

	// instruction reads are always whole words
	assign mem.req = (state == st_wait_ack);
	assign mem.we = 1'b0;
	assign mem.addr = pc[MEM_ADDR_W-1:0];
	assign mem.size = size_word;
	assign mem.wdata = '0;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= st_idle;
			pc <= RESET_PC;
			dec_start <= 1'b0;
		end else if (rdy_in) begin
			dec_start <= 1'b0;
			case (state)
				st_idle: begin
					state <= st_wait_ack;
				end
				st_wait_ack: begin
					if (mem.ack) begin
						instr <= mem.rdata;
						dec_start <= 1'b1;
						state <= st_wait_drop;
					end
				end
				st_wait_drop: begin
					if (!mem.ack) begin
						state <= st_wait_retire;
					end
				end
				st_wait_retire: begin
					// next request goes out the cycle after retire
					if (retire) begin
						pc <= next_pc;
						state <= st_wait_ack;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// File: reg_file.sv
// 32 x 32 register file, x0 reads as zero
`timescale 1ns/100ps

module reg_file (
	input logic clk_in,
	input logic rst_in,
	input cpu_pkg::reg_idx_t rs1_idx,
	input cpu_pkg::reg_idx_t rs2_idx,
	input logic wr_en,
	input cpu_pkg::reg_idx_t wr_idx,
	input cpu_pkg::word_t wr_data,
	output cpu_pkg::word_t rs1_data,
	output cpu_pkg::word_t rs2_data
);
	import cpu_pkg::*;

	word_t regs [32];

	assign rs1_data = regs[rs1_idx];
	assign rs2_data = regs[rs2_idx];

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

// File: alu.sv
// integer alu for the immediate and register forms
`timescale 1ns/100ps

module alu (
	input cpu_pkg::alu_op_e op,
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	output cpu_pkg::word_t y
);
	import cpu_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_sll: y = a << shamt;
			alu_slt: y = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: y = {31'b0, a < b};
			alu_xor: y = a ^ b;
			alu_srl: y = a >> shamt;
			alu_sra: y = $signed(a) >>> shamt;
			alu_or: y = a | b;
			alu_and: y = a & b;
			default: y = '0;
		endcase
	end

endmodule

// File: mem_req_if.sv
// four-phase request channel between a memory client and the memory port
`timescale 1ns/100ps

interface mem_req_if;
	import cpu_pkg::*;

	logic req;
	logic ack;
	logic we;
	mem_addr_t addr;
	mem_size_e size;
	word_t wdata;
	word_t rdata;

	modport client (
		output req, we, addr, size, wdata,
		input ack, rdata
	);

	modport port (
		input req, we, addr, size, wdata,
		output ack, rdata
	);

endinterface

// File: cpu_pkg.sv
// rv32i core shared definitions
// bus widths, opcodes, alu operations and access sizes
package cpu_pkg;

	localparam int MEM_ADDR_W = 18;

	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [4:0] reg_idx_t;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// bus bytes in the access, minus one
	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd3
	} mem_size_e;

endpackage
